// File: fm_reg_top.f
+incdir+rtl
rtl/fm_pkg.sv
rtl/fm_slot_timer.sv
rtl/fm_write_fsm.sv
rtl/fm_op_regs.sv
rtl/fm_ch_regs.sv
rtl/fm_reg_top.sv
testbench/fm_reg_tb.sv

// File: rtl/fm_ch_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_ch_regs (
	input wire clk,
	input wire rst,
	input wire ch_up,
	input wire fm_pkg::reg_kind_e up_kind,
	input wire fm_pkg::reg_byte_u up_data,
	output wire [10:0] fnum,
	output wire [2:0] block,
	output wire [2:0] feedback,
	output wire [2:0] algorithm,
	output wire [1:0] pan,
	output wire [1:0] am_sens,
	output wire [2:0] pm_sens
);
	import fm_pkg::*;

	logic [`FM_CH_ENTRY_W-1:0] ring [0:`FM_CHANNELS-1];
	logic [`FM_CH_ENTRY_W-1:0] head;
	logic [10:0] n_fnum;
	logic [2:0] n_block;
	logic [2:0] n_fb;
	logic [2:0] n_alg;
	logic [1:0] n_pan;
	logic [1:0] n_ams;
	logic [2:0] n_pms;

	assign head = ring[0];
	assign {block, fnum, feedback, algorithm, pan, am_sens, pm_sens} = head;

	always_comb begin
		{n_block, n_fnum, n_fb, n_alg, n_pan, n_ams, n_pms} = head;
		if (ch_up) begin
			case (up_kind)
				KIND_FNUM_LO: n_fnum[7:0] = up_data.raw;
				// block and the top fnum bits share one write
				KIND_BLOCK_FNHI: begin
					n_block = up_data.blk_fnhi.block;
					n_fnum[10:8] = up_data.blk_fnhi.fnhi;
				end
				KIND_FB_ALG: {n_fb, n_alg} = {up_data.fb_alg.fb, up_data.fb_alg.alg};
				KIND_PAN_MS: begin
					n_pan = up_data.pan_ms.rl;
					n_ams = up_data.pan_ms.ams;
					n_pms = up_data.pan_ms.pms;
				end
				default: ;
			endcase
		end
	end

	// one entry per channel, head is the current slot's channel
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_CHANNELS; i++) begin
				ring[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `FM_CHANNELS - 1; i++) begin
				ring[i] <= ring[i+1];
			end
			ring[`FM_CHANNELS-1] <= {n_block, n_fnum, n_fb, n_alg, n_pan, n_ams, n_pms};
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_consts.svh
`ifndef FM_CONSTS_SVH
`define FM_CONSTS_SVH

// frame geometry
`define FM_SLOTS 24
`define FM_CHANNELS 6

// apb address layout, channel sits below the operator field
`define FM_ADDR_W 9
`define FM_KIND_LSB 5
`define FM_OP_LSB 3

// ring entry widths
`define FM_OP_ENTRY_W 45
`define FM_CH_ENTRY_W 27

// register kind codes
`define FM_KIND_DT_MUL 4'd0
`define FM_KIND_TL 4'd1
`define FM_KIND_KS_AR 4'd2
`define FM_KIND_AM_D1R 4'd3
`define FM_KIND_D2R 4'd4
`define FM_KIND_D1L_RR 4'd5
`define FM_KIND_SSG 4'd6
`define FM_KIND_FNUM_LO 4'd8
`define FM_KIND_BLOCK_FNHI 4'd9
`define FM_KIND_FB_ALG 4'd10
`define FM_KIND_PAN_MS 4'd11
`define FM_KIND_KEYON 4'd12

// write fsm states
`define FM_ST_IDLE 2'd0
`define FM_ST_WAIT 2'd1
`define FM_ST_RESP 2'd2

`endif

// File: rtl/fm_op_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_op_regs (
	input wire clk,
	input wire rst,
	input wire op_up,
	input wire kon_up,
	input wire fm_pkg::reg_kind_e up_kind,
	input wire fm_pkg::reg_byte_u up_data,
	input wire [2:0] slot_ch,
	output wire [2:0] detune,
	output wire [3:0] multiple,
	output wire [6:0] total_level,
	output wire [1:0] key_scale,
	output wire [4:0] attack_rate,
	output wire am_enable,
	output wire [4:0] decay1_rate,
	output wire [4:0] decay2_rate,
	output wire [3:0] sustain_level,
	output wire [3:0] release_rate,
	output wire ssg_enable,
	output wire [2:0] ssg_mode,
	output wire keyon
);
	import fm_pkg::*;

	logic [`FM_OP_ENTRY_W-1:0] ring [0:`FM_SLOTS-1];
	logic [`FM_OP_ENTRY_W-1:0] head;
	logic [`FM_OP_ENTRY_W-1:0] merged;
	logic [3:0] kon_mask [0:`FM_CHANNELS-1];
	logic [1:0] head_op;
	logic [2:0] n_dt;
	logic [3:0] n_mul;
	logic [6:0] n_tl;
	logic [1:0] n_ks;
	logic [4:0] n_ar;
	logic n_amen;
	logic [4:0] n_d1r;
	logic [4:0] n_d2r;
	logic [3:0] n_d1l;
	logic [3:0] n_rr;
	logic n_ssg_en;
	logic [2:0] n_ssg_mode;

	assign head = ring[0];
	assign {keyon, detune, multiple, total_level, key_scale, attack_rate, am_enable,
		decay1_rate, decay2_rate, sustain_level, release_rate, ssg_enable, ssg_mode} = head;

	always_comb begin
		{n_dt, n_mul, n_tl, n_ks, n_ar, n_amen, n_d1r, n_d2r, n_d1l, n_rr, n_ssg_en,
			n_ssg_mode} = head[`FM_OP_ENTRY_W-2:0];
		if (op_up) begin
			case (up_kind)
				KIND_DT_MUL: {n_dt, n_mul} = {up_data.dt_mul.dt, up_data.dt_mul.mul};
				KIND_TL: n_tl = up_data.raw[6:0];
				KIND_KS_AR: {n_ks, n_ar} = {up_data.ks_ar.ks, up_data.ks_ar.ar};
				KIND_AM_D1R: {n_amen, n_d1r} = {up_data.am_d1r.amen, up_data.am_d1r.d1r};
				KIND_D2R: n_d2r = up_data.raw[4:0];
				KIND_D1L_RR: {n_d1l, n_rr} = {up_data.d1l_rr.d1l, up_data.d1l_rr.rr};
				KIND_SSG: {n_ssg_en, n_ssg_mode} = {up_data.ssg.en, up_data.ssg.mode};
				default: ;
			endcase
		end
		// key bit always refreshed from the channel's latest mask
		merged = {kon_mask[slot_ch][head_op], n_dt, n_mul, n_tl, n_ks, n_ar, n_amen,
			n_d1r, n_d2r, n_d1l, n_rr, n_ssg_en, n_ssg_mode};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_op <= 2'd0;
			for (int i = 0; i < `FM_SLOTS; i++) begin
				ring[i] <= '0;
			end
			for (int c = 0; c < `FM_CHANNELS; c++) begin
				kon_mask[c] <= 4'd0;
			end
		end else begin
			// operator of the head entry, steps on each channel wrap
			if (slot_ch == `FM_CHANNELS - 1) begin
				head_op <= head_op + 2'd1;
			end
			for (int i = 0; i < `FM_SLOTS - 1; i++) begin
				ring[i] <= ring[i+1];
			end
			ring[`FM_SLOTS-1] <= merged;
			if (kon_up) begin
				kon_mask[up_data.keyon.ch] <= up_data.keyon.mask;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_pkg.sv
`default_nettype none

`include "fm_consts.svh"

package fm_pkg;

	typedef enum logic [3:0] {
		KIND_DT_MUL = `FM_KIND_DT_MUL,
		KIND_TL = `FM_KIND_TL,
		KIND_KS_AR = `FM_KIND_KS_AR,
		KIND_AM_D1R = `FM_KIND_AM_D1R,
		KIND_D2R = `FM_KIND_D2R,
		KIND_D1L_RR = `FM_KIND_D1L_RR,
		KIND_SSG = `FM_KIND_SSG,
		KIND_FNUM_LO = `FM_KIND_FNUM_LO,
		KIND_BLOCK_FNHI = `FM_KIND_BLOCK_FNHI,
		KIND_FB_ALG = `FM_KIND_FB_ALG,
		KIND_PAN_MS = `FM_KIND_PAN_MS,
		KIND_KEYON = `FM_KIND_KEYON
	} reg_kind_e;

	// one written byte, field layout depends on the register kind
	typedef union packed {
		logic [7:0] raw;
		struct packed {logic pad; logic [2:0] dt; logic [3:0] mul;} dt_mul;
		struct packed {logic [1:0] ks; logic pad; logic [4:0] ar;} ks_ar;
		struct packed {logic amen; logic [1:0] pad; logic [4:0] d1r;} am_d1r;
		struct packed {logic [3:0] d1l; logic [3:0] rr;} d1l_rr;
		struct packed {logic [3:0] pad; logic en; logic [2:0] mode;} ssg;
		struct packed {logic [1:0] pad; logic [2:0] block; logic [2:0] fnhi;} blk_fnhi;
		struct packed {logic [1:0] pad; logic [2:0] fb; logic [2:0] alg;} fb_alg;
		struct packed {logic [1:0] rl; logic [1:0] ams; logic pad; logic [2:0] pms;} pan_ms;
		struct packed {logic [3:0] mask; logic pad; logic [2:0] ch;} keyon;
	} reg_byte_u;

endpackage

`default_nettype wire

// File: rtl/fm_reg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_reg_top (
	input wire clk,
	input wire rst,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`FM_ADDR_W-1:0] paddr,
	input wire [7:0] pwdata,
	output wire pready,
	output wire pslverr,
	output wire [4:0] slot,
	output wire [2:0] ch,
	output wire [1:0] op,
	output wire frame_start,
	// operator parameters
	output wire [2:0] detune,
	output wire [3:0] multiple,
	output wire [6:0] total_level,
	output wire [1:0] key_scale,
	output wire [4:0] attack_rate,
	output wire am_enable,
	output wire [4:0] decay1_rate,
	output wire [4:0] decay2_rate,
	output wire [3:0] sustain_level,
	output wire [3:0] release_rate,
	output wire ssg_enable,
	output wire [2:0] ssg_mode,
	output wire keyon,
	// channel parameters
	output wire [10:0] fnum,
	output wire [2:0] block,
	output wire [2:0] feedback,
	output wire [2:0] algorithm,
	output wire [1:0] pan,
	output wire [1:0] am_sens,
	output wire [2:0] pm_sens
);
	import fm_pkg::*;

	wire op_up;
	wire ch_up;
	wire kon_up;
	reg_kind_e up_kind;
	reg_byte_u up_data;

	fm_slot_timer u_timer (
		.clk(clk),
		.rst(rst),
		.slot(slot),
		.slot_ch(ch),
		.slot_op(op),
		.frame_start(frame_start)
	);

	fm_write_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.slot(slot),
		.slot_ch(ch),
		.pready(pready),
		.pslverr(pslverr),
		.op_up(op_up),
		.ch_up(ch_up),
		.kon_up(kon_up),
		.up_kind(up_kind),
		.up_data(up_data)
	);

	fm_op_regs u_op_regs (
		.clk(clk),
		.rst(rst),
		.op_up(op_up),
		.kon_up(kon_up),
		.up_kind(up_kind),
		.up_data(up_data),
		.slot_ch(ch),
		.detune(detune),
		.multiple(multiple),
		.total_level(total_level),
		.key_scale(key_scale),
		.attack_rate(attack_rate),
		.am_enable(am_enable),
		.decay1_rate(decay1_rate),
		.decay2_rate(decay2_rate),
		.sustain_level(sustain_level),
		.release_rate(release_rate),
		.ssg_enable(ssg_enable),
		.ssg_mode(ssg_mode),
		.keyon(keyon)
	);

	fm_ch_regs u_ch_regs (
		.clk(clk),
		.rst(rst),
		.ch_up(ch_up),
		.up_kind(up_kind),
		.up_data(up_data),
		.fnum(fnum),
		.block(block),
		.feedback(feedback),
		.algorithm(algorithm),
		.pan(pan),
		.am_sens(am_sens),
		.pm_sens(pm_sens)
	);

endmodule

`default_nettype wire

// File: rtl/fm_slot_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_slot_timer (
	input wire clk,
	input wire rst,
	output logic [4:0] slot,
	output logic [2:0] slot_ch,
	output logic [1:0] slot_op,
	output wire frame_start
);

	// channel and operator kept as counters next to the slot count
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= 5'd0;
			slot_ch <= 3'd0;
			slot_op <= 2'd0;
		end else begin
			if (slot == `FM_SLOTS - 1) begin
				slot <= 5'd0;
			end else begin
				slot <= slot + 5'd1;
			end
			if (slot_ch == `FM_CHANNELS - 1) begin
				slot_ch <= 3'd0;
				slot_op <= slot_op + 2'd1;
			end else begin
				slot_ch <= slot_ch + 3'd1;
			end
		end
	end

	assign frame_start = (slot == 5'd0);

endmodule

`default_nettype wire

// File: rtl/fm_write_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_write_fsm (
	input wire clk,
	input wire rst,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`FM_ADDR_W-1:0] paddr,
	input wire [7:0] pwdata,
	input wire [4:0] slot,
	input wire [2:0] slot_ch,
	output wire pready,
	output wire pslverr,
	output wire op_up,
	output wire ch_up,
	output wire kon_up,
	output fm_pkg::reg_kind_e up_kind,
	output fm_pkg::reg_byte_u up_data
);
	import fm_pkg::*;

	logic [1:0] state;
	logic err_q;
	reg_kind_e kind_q;
	reg_byte_u data_q;
	logic [4:0] tgt_slot;
	logic [2:0] tgt_ch;
	logic wait_ch;

	reg_kind_e kind_in;
	reg_byte_u data_in;
	logic [1:0] op_in;
	logic [2:0] ch_in;
	logic [4:0] slot_in;
	logic is_op_kind;
	logic is_ch_kind;
	logic is_kon_kind;
	logic valid;
	logic access;

	assign kind_in = reg_kind_e'(paddr[`FM_KIND_LSB +: 4]);
	assign op_in = paddr[`FM_OP_LSB +: 2];
	assign ch_in = paddr[`FM_OP_LSB-1:0];
	assign data_in = pwdata;
	// op * 6 + ch
	assign slot_in = {1'b0, op_in, 2'b00} + {2'b00, op_in, 1'b0} + {2'b00, ch_in};

	always_comb begin
		is_op_kind = 1'b0;
		is_ch_kind = 1'b0;
		is_kon_kind = 1'b0;
		case (kind_in)
			KIND_DT_MUL, KIND_TL, KIND_KS_AR, KIND_AM_D1R,
			KIND_D2R, KIND_D1L_RR, KIND_SSG: is_op_kind = 1'b1;
			KIND_FNUM_LO, KIND_BLOCK_FNHI, KIND_FB_ALG,
			KIND_PAN_MS: is_ch_kind = 1'b1;
			KIND_KEYON: is_kon_kind = 1'b1;
			default: ;
		endcase
	end

	// key-on carries its channel in the data byte
	assign valid = pwrite &&
		(((is_op_kind || is_ch_kind) && (ch_in < `FM_CHANNELS)) ||
		(is_kon_kind && (data_in.keyon.ch < `FM_CHANNELS)));

	assign access = (state == `FM_ST_IDLE) && psel && penable;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= `FM_ST_IDLE;
			err_q <= 1'b0;
		end else begin
			case (state)
				`FM_ST_IDLE: begin
					if (access) begin
						err_q <= !valid;
						if (valid && !is_kon_kind) begin
							state <= `FM_ST_WAIT;
						end else begin
							state <= `FM_ST_RESP;
						end
					end
				end
				`FM_ST_WAIT: begin
					if (op_up || ch_up) begin
						state <= `FM_ST_RESP;
					end
				end
				default: state <= `FM_ST_IDLE;
			endcase
		end
	end

	// decoded transfer, held while waiting for the slot
	always_ff @(posedge clk) begin
		if (access) begin
			kind_q <= kind_in;
			data_q <= data_in;
			tgt_slot <= slot_in;
			tgt_ch <= ch_in;
			wait_ch <= is_ch_kind;
		end
	end

	assign kon_up = access && valid && is_kon_kind;
	assign op_up = (state == `FM_ST_WAIT) && !wait_ch && (slot == tgt_slot);
	assign ch_up = (state == `FM_ST_WAIT) && wait_ch && (slot_ch == tgt_ch);

	// key-on goes out straight from the bus, slot writes from the held copy
	assign up_kind = (state == `FM_ST_IDLE) ? kind_in : kind_q;
	assign up_data = (state == `FM_ST_IDLE) ? data_in : data_q;

	assign pready = (state == `FM_ST_RESP);
	assign pslverr = (state == `FM_ST_RESP) && err_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fm_reg_tb -f fm_reg_top.f -o fm_reg_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/fm_reg_sim | tee sim.log
grep -qxF "*** PASSED ***" sim.log && echo "simulation ok" \
	|| { echo "simulation reported failure"; exit 1; }

// File: testbench/fm_reg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fm_consts.svh"

module fm_reg_tb;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`FM_ADDR_W-1:0] paddr;
	logic [7:0] pwdata;
	wire pready;
	wire pslverr;
	wire [4:0] slot;
	wire [2:0] ch;
	wire [1:0] op;
	wire frame_start;
	wire [2:0] detune;
	wire [3:0] multiple;
	wire [6:0] total_level;
	wire [1:0] key_scale;
	wire [4:0] attack_rate;
	wire am_enable;
	wire [4:0] decay1_rate;
	wire [4:0] decay2_rate;
	wire [3:0] sustain_level;
	wire [3:0] release_rate;
	wire ssg_enable;
	wire [2:0] ssg_mode;
	wire keyon;
	wire [10:0] fnum;
	wire [2:0] block;
	wire [2:0] feedback;
	wire [2:0] algorithm;
	wire [1:0] pan;
	wire [1:0] am_sens;
	wire [2:0] pm_sens;

	// trace records
	logic [3:0] tr_kind [$];
	logic [1:0] tr_op [$];
	logic [2:0] tr_ch [$];
	logic [7:0] tr_data [$];
	logic tr_rd [$];
	logic tr_err [$];

	// transfer in flight, read by the model
	logic [3:0] cur_kind;
	logic [1:0] cur_op;
	logic [2:0] cur_ch;
	logic [7:0] cur_data;

	// reference model, one entry per slot or channel
	int m_dt [0:`FM_SLOTS-1];
	int m_mul [0:`FM_SLOTS-1];
	int m_tl [0:`FM_SLOTS-1];
	int m_ks [0:`FM_SLOTS-1];
	int m_ar [0:`FM_SLOTS-1];
	int m_amen [0:`FM_SLOTS-1];
	int m_d1r [0:`FM_SLOTS-1];
	int m_d2r [0:`FM_SLOTS-1];
	int m_d1l [0:`FM_SLOTS-1];
	int m_rr [0:`FM_SLOTS-1];
	int m_ssg_en [0:`FM_SLOTS-1];
	int m_ssg_mode [0:`FM_SLOTS-1];
	int m_key [0:`FM_SLOTS-1];
	int m_mask [0:`FM_CHANNELS-1];
	int m_fnum [0:`FM_CHANNELS-1];
	int m_block [0:`FM_CHANNELS-1];
	int m_fb [0:`FM_CHANNELS-1];
	int m_alg [0:`FM_CHANNELS-1];
	int m_pan [0:`FM_CHANNELS-1];
	int m_ams [0:`FM_CHANNELS-1];
	int m_pms [0:`FM_CHANNELS-1];

	int exp_slot = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;
	integer seed = 81;

	fm_reg_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_val(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			$display("ERR %s cycle %0d expected 0x%0h actual 0x%0h", name, cycles, exp, act);
			errors++;
		end
	endtask

	// field layouts follow the register map of each kind
	task automatic apply_write(input logic [3:0] k, input logic [1:0] o, input logic [2:0] c,
		input logic [7:0] d);
		int s;
		s = int'(o) * 6 + int'(c);
		case (k)
			`FM_KIND_DT_MUL: begin
				m_dt[s] = int'(d[6:4]);
				m_mul[s] = int'(d[3:0]);
			end
			`FM_KIND_TL: m_tl[s] = int'(d[6:0]);
			`FM_KIND_KS_AR: begin
				m_ks[s] = int'(d[7:6]);
				m_ar[s] = int'(d[4:0]);
			end
			`FM_KIND_AM_D1R: begin
				m_amen[s] = int'(d[7]);
				m_d1r[s] = int'(d[4:0]);
			end
			`FM_KIND_D2R: m_d2r[s] = int'(d[4:0]);
			`FM_KIND_D1L_RR: begin
				m_d1l[s] = int'(d[7:4]);
				m_rr[s] = int'(d[3:0]);
			end
			`FM_KIND_SSG: begin
				m_ssg_en[s] = int'(d[3]);
				m_ssg_mode[s] = int'(d[2:0]);
			end
			`FM_KIND_FNUM_LO: m_fnum[c] = (m_fnum[c] & 'h700) | int'(d);
			`FM_KIND_BLOCK_FNHI: begin
				m_block[c] = int'(d[5:3]);
				m_fnum[c] = (m_fnum[c] & 'hff) | (int'(d[2:0]) << 8);
			end
			`FM_KIND_FB_ALG: begin
				m_fb[c] = int'(d[5:3]);
				m_alg[c] = int'(d[2:0]);
			end
			`FM_KIND_PAN_MS: begin
				m_pan[c] = int'(d[7:6]);
				m_ams[c] = int'(d[5:4]);
				m_pms[c] = int'(d[2:0]);
			end
			// key-on names its channel in the data byte
			`FM_KIND_KEYON: m_mask[d[2:0]] = int'(d[7:4]);
			default: ;
		endcase
	endtask

	// per-cycle compare against the current slot
	always @(negedge clk) begin : model_check
		int s;
		int c;
		int o;
		if (!rst) begin
			s = exp_slot;
			c = s % `FM_CHANNELS;
			o = s / `FM_CHANNELS;
			check_val("slot", s, int'(slot));
			check_val("frame_start", (s == 0) ? 1 : 0, int'(frame_start));
			check_val("ch", c, int'(ch));
			check_val("op", o, int'(op));
			check_val("detune", m_dt[s], int'(detune));
			check_val("multiple", m_mul[s], int'(multiple));
			check_val("total_level", m_tl[s], int'(total_level));
			check_val("key_scale", m_ks[s], int'(key_scale));
			check_val("attack_rate", m_ar[s], int'(attack_rate));
			check_val("am_enable", m_amen[s], int'(am_enable));
			check_val("decay1_rate", m_d1r[s], int'(decay1_rate));
			check_val("decay2_rate", m_d2r[s], int'(decay2_rate));
			check_val("sustain_level", m_d1l[s], int'(sustain_level));
			check_val("release_rate", m_rr[s], int'(release_rate));
			check_val("ssg_enable", m_ssg_en[s], int'(ssg_enable));
			check_val("ssg_mode", m_ssg_mode[s], int'(ssg_mode));
			check_val("keyon", m_key[s], int'(keyon));
			check_val("fnum", m_fnum[c], int'(fnum));
			check_val("block", m_block[c], int'(block));
			check_val("feedback", m_fb[c], int'(feedback));
			check_val("algorithm", m_alg[c], int'(algorithm));
			check_val("pan", m_pan[c], int'(pan));
			check_val("am_sens", m_ams[c], int'(am_sens));
			check_val("pm_sens", m_pms[c], int'(pm_sens));
			if (pready && !pslverr) begin
				apply_write(cur_kind, cur_op, cur_ch, cur_data);
			end
			// key bit picks up the mask as this slot passes, seen a frame later
			m_key[s] = (m_mask[c] >> o) & 1;
			exp_slot = (s == `FM_SLOTS - 1) ? 0 : s + 1;
		end
	end

	task automatic run_transfer(input int idx);
		int lat;
		@(posedge clk);
		cur_kind = tr_kind[idx];
		cur_op = tr_op[idx];
		cur_ch = tr_ch[idx];
		cur_data = tr_data[idx];
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= !tr_rd[idx];
		paddr <= {tr_kind[idx], tr_op[idx], tr_ch[idx]};
		pwdata <= tr_data[idx];
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		// cycles counted from the first access cycle
		lat = 0;
		while (!pready) begin
			@(negedge clk);
			lat++;
		end
		assert (lat <= 25) else begin
			$display("transfer %0d needed %0d cycles to complete, more than 25", idx, lat);
			errors++;
		end
		check_val($sformatf("txn%0d pslverr", idx), int'(tr_err[idx]), int'(pslverr));
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	initial begin : stimulus
		int fd;
		int n;
		int k;
		int o;
		int c;
		int d;
		int r;
		int e;
		int gap;
		string line;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = 8'd0;
		fd = $fopen("testbench/fm_reg_trace.txt", "r");
		if (fd == 0) begin
			$display("trace file testbench/fm_reg_trace.txt could not be opened");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h", k, o, c, d, r, e);
					if (n == 6) begin
						tr_kind.push_back(4'(k));
						tr_op.push_back(2'(o));
						tr_ch.push_back(3'(c));
						tr_data.push_back(8'(d));
						tr_rd.push_back(1'(r));
						tr_err.push_back(1'(e));
					end
				end
			end
			$fclose(fd);
		end
		if (fd != 0 && tr_kind.size() == 0) begin
			$display("trace file holds no transfers");
			errors++;
		end
		limit = tr_kind.size() * 32 + 100;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < tr_kind.size(); i++) begin
			gap = $unsigned($random(seed)) % 6;
			repeat (gap) @(posedge clk);
			run_transfer(i);
		end
		// two frames so the last writes reach their slots
		repeat (2 * `FM_SLOTS) @(posedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/fm_reg_trace.txt
# columns in hex: kind operator channel data read_flag expected_pslverr
# kinds 0-6 operator, 8-11 channel, 12 key-on (channel taken from data bits 2:0)
0 0 0 35 0 0
0 3 5 7f 0 0
1 1 2 5a 0 0
1 2 4 ff 0 0
2 0 3 d9 0 0
3 2 1 b3 0 0
4 3 0 1e 0 0
5 1 5 c4 0 0
6 2 2 0d 0 0
6 0 0 f3 0 0
8 0 1 a5 0 0
9 0 1 2e 0 0
8 3 4 ff 0 0
9 2 4 ff 0 0
a 0 2 e5 0 0
b 0 3 f7 0 0
c 0 0 51 0 0
c 0 0 a1 0 0
c 0 0 f4 0 0
c 0 0 30 0 0
7 0 0 55 0 1
d 1 1 55 0 1
f 2 2 aa 0 1
1 0 6 33 0 1
8 0 7 33 0 1
c 0 0 f6 0 1
1 1 1 44 1 1
0 0 0 ff 0 0
1 0 0 00 0 0
2 3 5 1f 0 0
